// File: tracking_engine.f
rtl/te_pkg.sv
rtl/te_regs.sv
rtl/te_sequencer.sv
rtl/te_channel_finder.sv
rtl/te_buffer_ram.sv
rtl/tracking_engine.sv
dv/te_sva.sv
dv/te_checker.sv
dv/tb_tracking_engine.sv

// File: dv/tb_tracking_engine.sv
`timescale 1ns/100ps

module tb_tracking_engine;

	import te_pkg::*;

	localparam int NUM_ROUNDS = 6;
	localparam int TIMEOUT    = 3000 + NUM_ROUNDS * 8 * 40;  // cycles

	logic clk = 0, rst_b = 0;
	logic i_te_start, i_fifo_ready, i_fifo_last_data;
	logic i_te_reg_cs, i_te_buffer_cs, i_te_rd, i_te_wr;
	host_addr_t i_te_addr;
	host_data_t i_te_d4wt;
	logic o_te_running, o_te_ready, o_te_over, o_fifo_read, o_fifo_rewind, o_fifo_skip;
	host_data_t o_te_rd_buffer, o_te_reg_d4rd;
	phys_en_t o_phys_en;
	chan_idx_t [PHYS_NUM-1:0] o_logic_index;
	host_addr_t buf_addrs [16];

	always #5 clk = ~clk;

	tracking_engine uut (.*);
	te_checker u_chk (.*);

	// one host access, then an idle cycle
	task automatic host_access(input logic reg_sel, rd, wr, input host_addr_t a,
		input host_data_t d);
		@(posedge clk);
		i_te_reg_cs    <= reg_sel;
		i_te_buffer_cs <= !reg_sel;
		i_te_rd        <= rd;
		i_te_wr        <= wr;
		i_te_addr      <= a;
		i_te_d4wt      <= d;
		@(posedge clk);
		{i_te_reg_cs, i_te_buffer_cs, i_te_rd, i_te_wr} <= '0;
	endtask

	task automatic run_round(input host_data_t mask);
		host_access(1, 0, 1, 14'd0, mask);
		host_access(1, 0, 1, 14'd1, $urandom | 32'h1);  // cleared by the start
		@(posedge clk);
		i_te_start <= 1'b1;
		do @(posedge clk); while (!o_te_running);
		i_te_start <= 1'b0;
		do @(posedge clk); while (!o_te_over);
		repeat (5) @(posedge clk);
		host_access(1, 1, 0, 14'd1, '0);
	endtask

	// fifo model, last data after a random delay
	initial begin
		forever begin
			@(posedge clk);
			if (o_fifo_read) begin
				repeat ($urandom_range(1, 20)) @(posedge clk);
				i_fifo_last_data <= 1'b1;
				@(posedge clk);
				i_fifo_last_data <= 1'b0;
			end
		end
	end

	initial begin
		repeat (TIMEOUT) @(posedge clk);
		$display("timeout, the DUT stopped answering after %0d cycles", TIMEOUT);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		void'($urandom(32'h6db0));
		{i_te_start, i_fifo_ready, i_fifo_last_data} = '0;
		{i_te_reg_cs, i_te_buffer_cs, i_te_rd, i_te_wr} = '0;
		i_te_addr = '0;
		i_te_d4wt = '0;
		repeat (10) @(posedge clk);
		rst_b <= 1'b1;
		i_fifo_ready <= 1'b1;

		//--------------------------------------------------------------------------
		for (int i = 0; i < 20; i++) begin
			host_access(1, 0, 1, 14'd0, $urandom);
			host_access(1, 0, 1, 14'd1, (i % 3) ? $urandom : 32'h0);
			for (int k = 0; k < 4; k++)
				host_access(1, 1, 0, k, '0);
			host_access(1, 1, 0,
				{8'($urandom_range(1, 255)), 6'd3 + 6'($urandom_range(0, 60))}, '0);
			host_access(1, 0, 0, 14'd0, '0);  // select without read
		end
		u_chk.end_test("registers");

		for (int i = 0; i < 16; i++) begin
			buf_addrs[i] = $urandom;
			host_access(0, 0, 1, buf_addrs[i], $urandom);
		end
		for (int i = 0; i < 16; i++)
			host_access(0, 1, 0, buf_addrs[$urandom_range(0, 15)], '0);
		u_chk.end_test("buffer");

		for (int r = 0; r < NUM_ROUNDS; r++)
			run_round(r == 3 ? 32'h0 : (r == 5 ? 32'hffff_ffff : $urandom & $urandom));
		u_chk.end_test("rounds");

		u_chk.final_counts(uut.u_sequencer.u_sva.fail_count);
		if (u_chk.err_total == 0 && uut.u_sequencer.u_sva.fail_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: dv/te_checker.sv
`timescale 1ns/100ps

module te_checker (
	input logic                                     clk,
	input logic                                     rst_b,
	input logic                                     i_te_start,
	input logic                                     i_fifo_last_data,
	input logic                                     i_te_reg_cs,
	input logic                                     i_te_buffer_cs,
	input logic                                     i_te_rd,
	input logic                                     i_te_wr,
	input te_pkg::host_addr_t                       i_te_addr,
	input te_pkg::host_data_t                       i_te_d4wt,
	input logic                                     o_te_running,
	input logic                                     o_te_ready,
	input logic                                     o_te_over,
	input logic                                     o_fifo_read,
	input logic                                     o_fifo_rewind,
	input logic                                     o_fifo_skip,
	input te_pkg::host_data_t                       o_te_rd_buffer,
	input te_pkg::host_data_t                       o_te_reg_d4rd,
	input te_pkg::phys_en_t                         o_phys_en,
	input te_pkg::chan_idx_t [te_pkg::PHYS_NUM-1:0] o_logic_index
);

	import te_pkg::*;

	logic [31:0] m_enable, m_coh, m_remain, exp_rd, buf_exp;
	logic [31:0] mem_model [BUF_DEPTH];
	logic [3:0]  exp_en;
	int          exp_idx [4];
	int          err_total = 0, err_test = 0, tests = 0;
	int          reads, rewinds, pop, since_last, n;
	logic        buf_pend = 0, last_seen = 0, after_over = 0, prev_running = 0;

	task automatic note_mismatch(input string name, input logic [31:0] exp, got);
		$display("error: %s expected %h got %h at %0t", name, exp, got, $time);
		err_test++;
		err_total++;
	endtask

	task automatic note_failure(input string msg);
		$display("failure at %0t: %s", $time, msg);
		err_test++;
		err_total++;
	endtask

	// called by the testbench as each test finishes
	task automatic end_test(input string name);
		tests++;
		$display("test %-12s %s (%0d errors)", name, err_test ? "fail" : "ok", err_test);
		err_test = 0;
	endtask

	task automatic final_counts(input int assert_fails);
		$display("%0d tests, %0d errors, %0d assertion failures",
			tests, err_total, assert_fails);
	endtask

	always @(posedge clk) begin
		if (rst_b) begin
			// register model and read mux
			exp_rd = '0;
			if (i_te_reg_cs && i_te_rd && i_te_addr[5:0] == 6'd0) exp_rd = m_enable;
			if (i_te_reg_cs && i_te_rd && i_te_addr[5:0] == 6'd1) exp_rd = m_coh;
			if (i_te_reg_cs && i_te_rd && i_te_addr[5:0] == 6'd2) begin
				if ((o_te_reg_d4rd & 32'hfff0_fff0) != 0)
					note_mismatch("o_te_reg_d4rd", 32'h0, o_te_reg_d4rd & 32'hfff0_fff0);
			end else if (o_te_reg_d4rd !== exp_rd) begin
				note_mismatch("o_te_reg_d4rd", exp_rd, o_te_reg_d4rd);
			end
			if (o_te_ready !== |m_coh)
				note_mismatch("o_te_ready", |m_coh, o_te_ready);
			if (i_te_reg_cs && i_te_wr && i_te_addr[5:0] == 6'd0) m_enable = i_te_d4wt;
			if (i_te_reg_cs && i_te_wr && i_te_addr[5:0] == 6'd1) m_coh = i_te_d4wt;

			// buffer, data one cycle after the read
			if (buf_pend && o_te_rd_buffer !== buf_exp)
				note_mismatch("o_te_rd_buffer", buf_exp, o_te_rd_buffer);
			buf_pend = i_te_buffer_cs && i_te_rd;
			buf_exp  = mem_model[i_te_addr[9:0]];
			if (i_te_buffer_cs && i_te_wr) mem_model[i_te_addr[9:0]] = i_te_d4wt;

			// round start, snapshot of the mask
			if (o_te_running && !prev_running) begin
				m_remain = m_enable;
				m_coh    = '0;
				pop      = $countones(m_enable);
				reads    = 0;
				rewinds  = 0;
			end
			prev_running = o_te_running;

			if (after_over && o_te_running) note_failure("o_te_running high before restart");
			if (i_te_start) after_over = 0;

			since_last = i_fifo_last_data ? 0 : since_last + 1;
			if (i_fifo_last_data) last_seen = 1;

			// next group, ascending, up to four
			if (o_fifo_read) begin
				exp_en = '0;
				n = 0;
				for (int i = 0; i < 32; i++) begin
					if (m_remain[i] && n < 4) begin
						exp_en[n]   = 1'b1;
						exp_idx[n]  = i;
						m_remain[i] = 1'b0;
						n++;
					end
				end
				if (o_phys_en !== exp_en) note_mismatch("o_phys_en", exp_en, o_phys_en);
				for (int j = 0; j < 4; j++)
					if (exp_en[j] && o_logic_index[j] !== exp_idx[j])
						note_mismatch("o_logic_index", exp_idx[j], o_logic_index[j]);
				reads++;
				last_seen = 0;
			end

			if ((o_fifo_rewind || o_te_over) && reads > 0 && (!last_seen || since_last < 6))
				note_failure("group ended before the correlation wait");
			if (o_fifo_rewind) rewinds++;
			if (o_fifo_skip != o_te_over) note_failure("o_fifo_skip not with o_te_over");
			if (o_te_over) begin
				if (reads != (pop + 3) / 4) note_mismatch("read count", (pop + 3) / 4, reads);
				if (rewinds != (reads ? reads - 1 : 0))
					note_mismatch("rewind count", reads ? reads - 1 : 0, rewinds);
				after_over = 1;
			end
		end else begin
			m_enable = '0;  // registers clear in reset
			m_coh    = '0;
		end
	end

endmodule

// File: dv/te_sva.sv
`timescale 1ns/100ps

module te_sva (
	input logic clk,
	input logic rst_b,
	input logic o_fifo_read,
	input logic o_fifo_skip,
	input logic o_te_over,
	input logic o_te_running
);

	int fail_count = 0;  // failed assertions so far

	a_read_pulse: assert property (@(posedge clk) disable iff (!rst_b)
		o_fifo_read |=> !o_fifo_read)
	else begin
		$error("o_fifo_read wider than one cycle");
		fail_count++;
	end

	a_skip_pulse: assert property (@(posedge clk) disable iff (!rst_b)
		o_fifo_skip |=> !o_fifo_skip)
	else begin
		$error("o_fifo_skip wider than one cycle");
		fail_count++;
	end

	a_over_pulse: assert property (@(posedge clk) disable iff (!rst_b)
		o_te_over |=> !o_te_over)
	else begin
		$error("o_te_over wider than one cycle");
		fail_count++;
	end

	a_skip_with_over: assert property (@(posedge clk) disable iff (!rst_b)
		o_fifo_skip == o_te_over)
	else begin
		$error("o_fifo_skip and o_te_over apart");
		fail_count++;
	end

	// strobes and running flag come out of reset low
	a_reset_values: assert property (@(posedge clk)
		$rose(rst_b) |-> !o_te_running && !o_fifo_read && !o_fifo_skip && !o_te_over)
	else begin
		$error("outputs not at reset values after reset");
		fail_count++;
	end

endmodule

bind te_sequencer te_sva u_sva (.*);

// File: rtl/tracking_engine.sv
`timescale 1ns/100ps

module tracking_engine (
	input  logic                                     clk,
	input  logic                                     rst_b,
	// round control
	input  logic                                     i_te_start,
	output logic                                     o_te_running,
	output logic                                     o_te_ready,
	output logic                                     o_te_over,
	// fifo
	input  logic                                     i_fifo_ready,
	input  logic                                     i_fifo_last_data,
	output logic                                     o_fifo_read,
	output logic                                     o_fifo_rewind,
	output logic                                     o_fifo_skip,
	// host port
	input  logic                                     i_te_reg_cs,
	input  logic                                     i_te_buffer_cs,
	input  logic                                     i_te_rd,
	input  logic                                     i_te_wr,
	input  te_pkg::host_addr_t                       i_te_addr,
	input  te_pkg::host_data_t                       i_te_d4wt,
	output te_pkg::host_data_t                       o_te_rd_buffer,
	output te_pkg::host_data_t                       o_te_reg_d4rd,
	// current group, as it would feed the correlators
	output te_pkg::phys_en_t                         o_phys_en,
	output te_pkg::chan_idx_t [te_pkg::PHYS_NUM-1:0] o_logic_index
);

	import te_pkg::*;

	te_state_t  cur_state;
	te_state_t  next_state;
	chan_mask_t channel_enable;
	logic       any_enabled;
	logic       latch_mask;
	logic       find_start;
	logic       find_done;
	logic       all_done;

	//------------------------------------------------------------------------
	// host registers
	//------------------------------------------------------------------------
	te_regs u_regs (
		.clk              (clk),
		.rst_b            (rst_b),
		.i_te_reg_cs      (i_te_reg_cs),
		.i_te_rd          (i_te_rd),
		.i_te_wr          (i_te_wr),
		.i_te_addr        (i_te_addr),
		.i_te_d4wt        (i_te_d4wt),
		.o_te_reg_d4rd    (o_te_reg_d4rd),
		.i_cur_state      (cur_state),
		.i_next_state     (next_state),
		.o_channel_enable (channel_enable),
		.o_any_enabled    (any_enabled),
		.o_te_ready       (o_te_ready)
	);

	//------------------------------------------------------------------------
	// round control and group selection
	//------------------------------------------------------------------------
	te_sequencer u_sequencer (
		.clk              (clk),
		.rst_b            (rst_b),
		.i_te_start       (i_te_start),
		.i_fifo_ready     (i_fifo_ready),
		.i_fifo_last_data (i_fifo_last_data),
		.i_any_enabled    (any_enabled),
		.i_find_done      (find_done),
		.i_all_done       (all_done),
		.o_cur_state      (cur_state),
		.o_next_state     (next_state),
		.o_latch_mask     (latch_mask),
		.o_find_start     (find_start),
		.o_fifo_read      (o_fifo_read),
		.o_fifo_rewind    (o_fifo_rewind),
		.o_fifo_skip      (o_fifo_skip),
		.o_te_over        (o_te_over),
		.o_te_running     (o_te_running)
	);

	te_channel_finder u_channel_finder (
		.clk              (clk),
		.rst_b            (rst_b),
		.i_latch_mask     (latch_mask),
		.i_channel_enable (channel_enable),
		.i_find_start     (find_start),
		.o_find_done      (find_done),
		.o_all_done       (all_done),
		.o_phys_en        (o_phys_en),
		.o_logic_index    (o_logic_index)
	);

	// host buffer, own chip select
	te_buffer_ram u_buffer_ram (
		.clk              (clk),
		.i_te_buffer_cs   (i_te_buffer_cs),
		.i_te_rd          (i_te_rd),
		.i_te_wr          (i_te_wr),
		.i_te_addr        (i_te_addr),
		.i_te_d4wt        (i_te_d4wt),
		.o_te_rd_buffer   (o_te_rd_buffer)
	);

endmodule

// File: rtl/te_buffer_ram.sv
`timescale 1ns/100ps

module te_buffer_ram (
	input  logic               clk,
	input  logic               i_te_buffer_cs,
	input  logic               i_te_rd,
	input  logic               i_te_wr,
	input  te_pkg::host_addr_t i_te_addr,
	input  te_pkg::host_data_t i_te_d4wt,
	output te_pkg::host_data_t o_te_rd_buffer  // valid the cycle after the read
);

	import te_pkg::*;

	host_data_t mem [BUF_DEPTH];
	buf_addr_t  buf_addr;

	assign buf_addr = i_te_addr[$bits(buf_addr_t)-1:0];

	// single port, write and registered read
	always_ff @(posedge clk) begin
		if (i_te_buffer_cs && i_te_wr)
			mem[buf_addr] <= i_te_d4wt;
		if (i_te_buffer_cs && i_te_rd)
			o_te_rd_buffer <= mem[buf_addr];
	end

endmodule

// File: rtl/te_channel_finder.sv
`timescale 1ns/100ps

module te_channel_finder (
	input  logic                                  clk,
	input  logic                                  rst_b,
	input  logic                                  i_latch_mask,
	input  te_pkg::chan_mask_t                    i_channel_enable,
	input  logic                                  i_find_start,
	output logic                                  o_find_done,  // one cycle at scan end
	output logic                                  o_all_done,   // nothing left this round
	output te_pkg::phys_en_t                      o_phys_en,
	output te_pkg::chan_idx_t [te_pkg::PHYS_NUM-1:0] o_logic_index
);

	import te_pkg::*;

	chan_mask_t                    remain;     // channels not yet assigned
	chan_idx_t                     scan_ptr;
	logic [$clog2(PHYS_NUM)-1:0]   slot;       // next free physical slot
	logic                          busy;
	logic                          hit;
	logic                          last_bit;
	logic                          group_full;
	logic                          scan_end;

	assign hit        = remain[scan_ptr];
	assign last_bit   = (scan_ptr == chan_idx_t'(CHANNEL_NUM - 1));
	assign group_full = hit && (slot == $bits(slot)'(PHYS_NUM - 1));
	assign scan_end   = busy && (last_bit || group_full);

	assign o_all_done = ~(|remain);

	//------------------------------------------------------------------------
	// remaining mask
	//------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			remain <= '0;
		end else if (i_latch_mask) begin
			remain <= i_channel_enable;  // snapshot at round start
		end else if (busy && hit) begin
			remain[scan_ptr] <= 1'b0;
		end
	end

	//------------------------------------------------------------------------
	// scan, one bit per cycle from index 0
	//------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			busy        <= 1'b0;
			scan_ptr    <= '0;
			slot        <= '0;
			o_find_done <= 1'b0;
		end else begin
			o_find_done <= scan_end;
			if (i_find_start) begin
				busy     <= 1'b1;
				scan_ptr <= '0;
				slot     <= '0;
			end else if (busy) begin
				scan_ptr <= scan_ptr + 1'b1;
				if (hit)
					slot <= slot + 1'b1;  // wraps only when the group is full
				if (scan_end)
					busy <= 1'b0;
			end
		end
	end

	// group outputs hold from scan end until the next scan starts
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			o_phys_en     <= '0;
			o_logic_index <= '0;
		end else if (i_find_start) begin
			o_phys_en     <= '0;
			o_logic_index <= '0;
		end else if (busy && hit) begin
			o_phys_en[slot]     <= 1'b1;
			o_logic_index[slot] <= scan_ptr;
		end
	end

endmodule

// File: rtl/te_sequencer.sv
`timescale 1ns/100ps

module te_sequencer (
	input  logic              clk,
	input  logic              rst_b,
	input  logic              i_te_start,        // level, host trigger
	// fifo status
	input  logic              i_fifo_ready,
	input  logic              i_fifo_last_data,  // pulse
	// from registers and channel finder
	input  logic              i_any_enabled,
	input  logic              i_find_done,
	input  logic              i_all_done,
	// state for readback
	output te_pkg::te_state_t o_cur_state,
	output te_pkg::te_state_t o_next_state,
	// to channel finder
	output logic              o_latch_mask,
	output logic              o_find_start,
	// fifo strobes, registered
	output logic              o_fifo_read,
	output logic              o_fifo_rewind,
	output logic              o_fifo_skip,
	// round status
	output logic              o_te_over,
	output logic              o_te_running
);

	import te_pkg::*;

	logic [COR_LATENCY-1:0] last_data_d;
	logic                   cor_done;

	//------------------------------------------------------------------------
	// round state machine
	//------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			o_cur_state <= STAND_BY;
		end else begin
			o_cur_state <= o_next_state;
		end
	end

	always_comb begin
		case (o_cur_state)
			STAND_BY:     o_next_state = i_te_start ? IDLE : STAND_BY;
			IDLE:         o_next_state = i_fifo_ready ? START : IDLE;
			START:        o_next_state = i_any_enabled ? FIND_CHANNEL : TE_FINISH;
			FIND_CHANNEL: o_next_state = i_find_done ? READ_FIFO : FIND_CHANNEL;
			READ_FIFO:    o_next_state = CORRELATION;
			CORRELATION:  o_next_state = cor_done ? COR_FINISH : CORRELATION;
			COR_FINISH:   o_next_state = i_all_done ? TE_FINISH : FIND_CHANNEL;
			TE_FINISH:    o_next_state = WAIT_CPU;
			WAIT_CPU:     o_next_state = i_te_start ? IDLE : WAIT_CPU;
			default:      o_next_state = STAND_BY;
		endcase
	end

	// correlators need COR_LATENCY cycles after the last sample
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			last_data_d <= '0;
		end else begin
			last_data_d <= {last_data_d[COR_LATENCY-2:0], i_fifo_last_data};
		end
	end

	assign cor_done = last_data_d[COR_LATENCY-1];

	//------------------------------------------------------------------------
	// strobes
	//------------------------------------------------------------------------
	assign o_latch_mask = (o_next_state == START);
	assign o_find_start = (o_cur_state != FIND_CHANNEL) && (o_next_state == FIND_CHANNEL);

	// registered from next state so each lines up with its state
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			o_fifo_read   <= 1'b0;
			o_fifo_rewind <= 1'b0;
			o_fifo_skip   <= 1'b0;
		end else begin
			o_fifo_read   <= (o_next_state == READ_FIFO);
			o_fifo_rewind <= (o_next_state == COR_FINISH) && !i_all_done;  // more groups left
			o_fifo_skip   <= (o_next_state == TE_FINISH);
		end
	end

	assign o_te_over    = (o_cur_state == TE_FINISH);
	assign o_te_running = (o_cur_state != STAND_BY) && (o_cur_state != WAIT_CPU);

endmodule

// File: rtl/te_regs.sv
`timescale 1ns/100ps

module te_regs (
	input  logic               clk,
	input  logic               rst_b,
	// host register port
	input  logic               i_te_reg_cs,
	input  logic               i_te_rd,
	input  logic               i_te_wr,
	input  te_pkg::host_addr_t i_te_addr,
	input  te_pkg::host_data_t i_te_d4wt,
	output te_pkg::host_data_t o_te_reg_d4rd,  // same cycle as the read
	// sequencer state for readback and the clear at start
	input  te_pkg::te_state_t  i_cur_state,
	input  te_pkg::te_state_t  i_next_state,
	// to sequencer and channel finder
	output te_pkg::chan_mask_t o_channel_enable,
	output logic               o_any_enabled,
	output logic               o_te_ready
);

	import te_pkg::*;

	logic [5:0] reg_offset;
	logic       reg_wr;
	logic       reg_rd;
	chan_mask_t coh_data_ready;

	assign reg_offset = i_te_addr[5:0];
	assign reg_wr     = i_te_reg_cs & i_te_wr;
	assign reg_rd     = i_te_reg_cs & i_te_rd;

	//------------------------------------------------------------------------
	// host written registers
	//------------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			o_channel_enable <= '0;
		end else if (reg_wr && (reg_offset == REG_CHANNEL_ENABLE)) begin
			o_channel_enable <= i_te_d4wt;
		end
	end

	// host write takes priority over the clear at round start
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			coh_data_ready <= '0;
		end else if (reg_wr && (reg_offset == REG_COH_DATA_READY)) begin
			coh_data_ready <= i_te_d4wt;
		end else if (i_next_state == START) begin
			coh_data_ready <= '0;  // new round
		end
	end

	assign o_any_enabled = |o_channel_enable;
	assign o_te_ready    = |coh_data_ready;

	//------------------------------------------------------------------------
	// read mux
	//------------------------------------------------------------------------
	always_comb begin
		o_te_reg_d4rd = '0;
		if (reg_rd) begin
			case (reg_offset)
				REG_CHANNEL_ENABLE: o_te_reg_d4rd = o_channel_enable;
				REG_COH_DATA_READY: o_te_reg_d4rd = coh_data_ready;
				REG_CURR_STATE:     o_te_reg_d4rd = {12'h0, i_next_state, 12'h0, i_cur_state};
				default:            o_te_reg_d4rd = '0;  // unknown offset
			endcase
		end
	end

endmodule

// File: rtl/te_pkg.sv
package te_pkg;

	//------------------------------------------------------------------------
	// sizes
	//------------------------------------------------------------------------
	localparam int CHANNEL_NUM = 32;    // logical channels
	localparam int PHYS_NUM    = 4;     // physical correlator slots
	localparam int COR_LATENCY = 5;     // cycles from last fifo data to correlator done
	localparam int BUF_DEPTH   = 1024;  // buffer words

	// register offsets, low 6 address bits
	localparam logic [5:0] REG_CHANNEL_ENABLE = 6'd0;
	localparam logic [5:0] REG_COH_DATA_READY = 6'd1;
	localparam logic [5:0] REG_CURR_STATE     = 6'd2;

	//------------------------------------------------------------------------
	// vector types
	//------------------------------------------------------------------------
	typedef logic [CHANNEL_NUM-1:0]         chan_mask_t;  // one bit per logical channel
	typedef logic [$clog2(CHANNEL_NUM)-1:0] chan_idx_t;
	typedef logic [PHYS_NUM-1:0]            phys_en_t;    // one bit per slot
	typedef logic [13:0]                    host_addr_t;
	typedef logic [31:0]                    host_data_t;
	typedef logic [$clog2(BUF_DEPTH)-1:0]   buf_addr_t;

	// round states, 4 bits to fit the readback field
	typedef enum logic [3:0] {
		IDLE         = 4'd0,
		START        = 4'd1,
		FIND_CHANNEL = 4'd2,
		READ_FIFO    = 4'd5,
		CORRELATION  = 4'd6,
		COR_FINISH   = 4'd9,
		TE_FINISH    = 4'd10,
		WAIT_CPU     = 4'd11,
		STAND_BY     = 4'd12
	} te_state_t;

endpackage
